//--- all.f
source/mipsPkg.sv
source/controller.sv
source/nextPc.sv
source/registerFile.sv
source/executeUnit.sv
source/dataMemory.sv
source/mips.sv
tests/mipsTb.sv

//--- source/controller.sv
`default_nettype none

module controller (
    input  logic [31:0]         instr,
    output mipsPkg::controlType control
);
    import mipsPkg::*;

    instrType  fields;
    opcodeType opcode;
    functType  funct;

    assign fields = instr;
    assign opcode = opcodeType'(fields.opcode);
    assign funct  = functType'(fields.funct);

    always_comb begin
        control.npcOp     = npcSequential;  // Anything not decoded below falls through as a no-op
        control.regDst    = regDstRt;
        control.wbSel     = wbAlu;
        control.extOp     = extZero;
        control.aluOp     = aluAdd;
        control.memSize   = memWord;
        control.regWrite  = 1'b0;
        control.memWrite  = 1'b0;
        control.aluSrcImm = 1'b0;
        control.shiftSrc  = 1'b0;

        case (opcode)
            opSpecial: begin
                control.regDst = regDstRd;
                case (funct)
                    functAddu: begin
                        control.regWrite = 1'b1;
                        control.aluOp    = aluAdd;
                    end
                    functSubu: begin
                        control.regWrite = 1'b1;
                        control.aluOp    = aluSub;
                    end
                    functAnd: begin
                        control.regWrite = 1'b1;
                        control.aluOp    = aluAnd;
                    end
                    functOr: begin
                        control.regWrite = 1'b1;
                        control.aluOp    = aluOr;
                    end
                    functSlt: begin
                        control.regWrite = 1'b1;
                        control.aluOp    = aluSlt;
                    end
                    functSll: begin
                        control.regWrite = 1'b1;
                        control.aluOp    = aluSll;
                        control.shiftSrc = 1'b1;  // Shift by shamt, not by rs
                    end
                    functJr: control.npcOp = npcRegister;
                    default: ;
                endcase
            end
            opOri: begin
                control.regWrite  = 1'b1;
                control.aluSrcImm = 1'b1;
                control.aluOp     = aluOr;
            end
            opLui: begin
                control.regWrite  = 1'b1;
                control.aluSrcImm = 1'b1;
                control.extOp     = extUpper;
                control.aluOp     = aluLui;
            end
            opAddiu: begin
                control.regWrite  = 1'b1;
                control.aluSrcImm = 1'b1;
                control.extOp     = extSign;
            end
            opLw, opLh, opLb: begin
                control.regWrite  = 1'b1;
                control.aluSrcImm = 1'b1;
                control.extOp     = extSign;
                control.wbSel     = wbMemory;
                control.memSize   = (opcode == opLw) ? memWord :
                                    (opcode == opLh) ? memHalf : memByte;
            end
            opSw, opSh, opSb: begin
                control.memWrite  = 1'b1;
                control.aluSrcImm = 1'b1;
                control.extOp     = extSign;
                control.memSize   = (opcode == opSw) ? memWord :
                                    (opcode == opSh) ? memHalf : memByte;
            end
            opBeq: begin
                control.npcOp = npcBranch;
                control.aluOp = aluSub;  // Equal operands leave a zero difference
            end
            opJ: control.npcOp = npcJump;
            opJal: begin
                control.npcOp    = npcJump;
                control.regWrite = 1'b1;
                control.regDst   = regDstRa31;
                control.wbSel    = wbLink;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/dataMemory.sv
`default_nettype none

module dataMemory #(
    parameter int memoryWords = 1024
) (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::controlType control,
    input  logic [31:0]         address,
    input  logic [31:0]         storeData,
    output logic [31:0]         loadData,
    output logic [3:0]          byteEnable,
    output logic [31:0]         laneData
);
    import mipsPkg::*;

    localparam int indexBits = $clog2(memoryWords);

    logic [31:0]          memory [memoryWords];
    logic [indexBits-1:0] wordIndex;
    logic [1:0]           byteOffset;
    logic [31:0]          wordData;
    logic [15:0]          halfData;
    logic [7:0]           byteData;
    logic [3:0]           laneSelect;

    assign wordIndex  = address[indexBits+1:2];  // Upper address bits wrap around
    assign byteOffset = address[1:0];
    assign wordData   = memory[wordIndex];

    always_comb begin
        case (control.memSize)
            memHalf: begin
                laneSelect = byteOffset[1] ? 4'b1100 : 4'b0011;
                laneData   = {16'd0, storeData[15:0]} << {byteOffset[1], 4'b0000};
            end
            memByte: begin
                laneSelect = 4'b0001 << byteOffset;
                laneData   = {24'd0, storeData[7:0]} << {byteOffset, 3'b000};
            end
            default: begin
                laneSelect = 4'b1111;
                laneData   = storeData;
            end
        endcase
    end

    assign byteEnable = control.memWrite ? laneSelect : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memoryWords; i++) begin
                memory[i] <= '0;
            end
        end else begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEnable[lane]) begin
                    memory[wordIndex][lane*8 +: 8] <= laneData[lane*8 +: 8];
                end
            end
        end
    end

    assign halfData = byteOffset[1] ? wordData[31:16] : wordData[15:0];
    assign byteData = wordData[{byteOffset, 3'b000} +: 8];  // Little-endian lane pick

    always_comb begin
        case (control.memSize)
            memHalf: loadData = {{16{halfData[15]}}, halfData};
            memByte: loadData = {{24{byteData[7]}}, byteData};
            default: loadData = wordData;
        endcase
    end

endmodule

`default_nettype wire

//--- source/executeUnit.sv
`default_nettype none

module executeUnit (
    input  logic [31:0]         readData1,
    input  logic [31:0]         readData2,
    input  mipsPkg::controlType control,
    input  logic [15:0]         immediate,
    input  logic [4:0]          shiftAmount,
    output logic [31:0]         result,
    output logic                zero
);
    import mipsPkg::*;

    logic [31:0] immExtended;
    logic [31:0] operandA;
    logic [31:0] operandB;

    always_comb begin
        case (control.extOp)
            extSign:  immExtended = {{16{immediate[15]}}, immediate};
            default:  immExtended = {16'd0, immediate};  // The ALU shifts this for lui
        endcase
    end

    assign operandA = control.shiftSrc  ? {27'd0, shiftAmount} : readData1;
    assign operandB = control.aluSrcImm ? immExtended : readData2;

    always_comb begin
        case (control.aluOp)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluSlt:  result = {31'd0, $signed(operandA) < $signed(operandB)};
            aluSll:  result = operandB << operandA[4:0];
            aluLui:  result = operandB << 16;
            default: result = operandA + operandB;
        endcase
    end

    assign zero = (result == 32'd0);  // Only beq looks at this

endmodule

`default_nettype wire

//--- source/mips.sv
`default_nettype none

module mips #(
    parameter int memoryWords = 1024
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [31:0]       instr,
    output logic [31:0]       instrAddr,
    output mipsPkg::traceType trace
);
    import mipsPkg::*;

    instrType    fields;
    controlType  control;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic [31:0] laneData;
    logic [31:0] writeData;
    logic [4:0]  writeAddr;
    logic [3:0]  byteEnable;
    logic        zero;

    assign fields    = instr;
    assign instrAddr = pc;  // Instruction memory answers within the same cycle

    controller mainController (
        .instr(instr),
        .control(control)
    );

    nextPc mainNpc (
        .clk(clk),
        .reset(reset),
        .control(control),
        .zero(zero),
        .immediate(instr[15:0]),
        .jumpIndex(instr[25:0]),
        .registerTarget(readData1),
        .pc(pc),
        .pcPlus4(pcPlus4)
    );

    registerFile mainRf (
        .clk(clk),
        .reset(reset),
        .writeEnable(control.regWrite),
        .readAddr1(fields.rs),
        .readAddr2(fields.rt),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readData1(readData1),
        .readData2(readData2)
    );

    executeUnit mainAlu (
        .readData1(readData1),
        .readData2(readData2),
        .control(control),
        .immediate(instr[15:0]),
        .shiftAmount(fields.shamt),
        .result(aluResult),
        .zero(zero)
    );

    dataMemory #(
        .memoryWords(memoryWords)
    ) mainDm (
        .clk(clk),
        .reset(reset),
        .control(control),
        .address(aluResult),
        .storeData(readData2),
        .loadData(loadData),
        .byteEnable(byteEnable),
        .laneData(laneData)
    );

    always_comb begin
        case (control.regDst)
            regDstRt:   writeAddr = fields.rt;
            regDstRd:   writeAddr = fields.rd;
            regDstRa31: writeAddr = 5'd31;  // Link register for jal
            default:    writeAddr = fields.rt;
        endcase
    end

    always_comb begin
        case (control.wbSel)
            wbAlu:    writeData = aluResult;
            wbMemory: writeData = loadData;
            wbLink:   writeData = pcPlus4;
            default:  writeData = aluResult;
        endcase
    end

    always_comb begin
        trace.pc            = pc;
        trace.regWrite      = control.regWrite && !reset;  // Nothing commits while in reset
        trace.regAddr       = writeAddr;
        trace.regData       = writeData;
        trace.memWrite      = control.memWrite && !reset;
        trace.memAddr       = aluResult;
        trace.memByteEnable = byteEnable;
        trace.memData       = laneData;
    end

endmodule

`default_nettype wire

//--- source/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam logic [31:0] resetAddress = 32'h0000_3000;  // First fetch after reset

    // Field layout of an R-type word, also used to pull opcode, rs and rt from I and J types
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrType;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,  // R type, function field selects the operation
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLb      = 6'h20,
        opLh      = 6'h21,
        opLw      = 6'h23,
        opSb      = 6'h28,
        opSh      = 6'h29,
        opSw      = 6'h2b
    } opcodeType;

    typedef enum logic [5:0] {
        functSll  = 6'h00,
        functJr   = 6'h08,
        functAddu = 6'h21,
        functSubu = 6'h23,
        functAnd  = 6'h24,
        functOr   = 6'h25,
        functSlt  = 6'h2a
    } functType;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluLui} aluOpType;

    typedef enum logic [1:0] {npcSequential, npcBranch, npcJump, npcRegister} npcOpType;

    typedef enum logic [1:0] {regDstRt, regDstRd, regDstRa31} regDstType;

    typedef enum logic [1:0] {wbAlu, wbMemory, wbLink} wbSelType;

    typedef enum logic [1:0] {extZero, extSign, extUpper} extOpType;

    typedef enum logic [1:0] {memWord, memHalf, memByte} memSizeType;

    typedef struct packed {
        npcOpType   npcOp;
        regDstType  regDst;
        wbSelType   wbSel;
        extOpType   extOp;
        aluOpType   aluOp;
        memSizeType memSize;
        logic       regWrite;
        logic       memWrite;
        logic       aluSrcImm;  // B operand is the extended immediate
        logic       shiftSrc;   // A operand is the shift amount
    } controlType;

    typedef struct packed {
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memWrite;
        logic [31:0] memAddr;        // Byte address
        logic [3:0]  memByteEnable;
        logic [31:0] memData;        // Store data already moved into its lanes
    } traceType;

endpackage

`default_nettype wire

//--- source/nextPc.sv
`default_nettype none

module nextPc (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::controlType control,
    input  logic                zero,
    input  logic [15:0]         immediate,
    input  logic [25:0]         jumpIndex,
    input  logic [31:0]         registerTarget,
    output logic [31:0]         pc,
    output logic [31:0]         pcPlus4
);
    import mipsPkg::*;

    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] pcNext;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{immediate[15]}}, immediate, 2'b00};  // Word offset
    assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};  // Stays in the current region

    always_comb begin
        case (control.npcOp)
            npcSequential: pcNext = pcPlus4;
            npcBranch:     pcNext = zero ? branchTarget : pcPlus4;
            npcJump:       pcNext = jumpTarget;
            npcRegister:   pcNext = registerTarget;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetAddress;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`default_nettype none

module registerFile (
    input  logic        clk,
    input  logic        reset,
    input  logic        writeEnable,
    input  logic [4:0]  readAddr1,
    input  logic [4:0]  readAddr2,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] registers [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && writeAddr != 5'd0) begin  // Register 0 never changes
            registers[writeAddr] <= writeData;
        end
    end

    // Register 0 reads as zero even before the first reset
    assign readData1 = (readAddr1 == 5'd0) ? 32'd0 : registers[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? 32'd0 : registers[readAddr2];

endmodule

`default_nettype wire

//--- tests/mipsTb.sv
`default_nettype none

module mipsTb;
    import mipsPkg::*;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    traceType    trace;
    logic [31:0] romWords [64];  // Instruction memory, indexed by address bits 7:2
    traceType    expected [$];   // Commits in execution order

    mips #(.memoryWords(1024)) i_dut (.*);

    function automatic logic [31:0] rFormat(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [4:0] shamt,
                                            input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addInstr(input logic [31:0] addr, input logic [31:0] word);
        romWords[addr[7:2]] = word;
    endtask

    task automatic addStep(input logic [31:0] pc, input logic regWrite, input logic [4:0] regAddr,
                           input logic [31:0] regData, input logic memWrite,
                           input logic [31:0] memAddr, input logic [3:0] byteEnable,
                           input logic [31:0] memData);
        expected.push_back(traceType'({pc, regWrite, regAddr, regData,
                                       memWrite, memAddr, byteEnable, memData}));
    endtask

    task automatic checkField(input int index, input string name,
                              input logic [31:0] actual, input logic [31:0] want);
        assert (actual === want) else begin
            $display("Error at time %0t: step %0d, %s is %h but should be %h",
                     $time, index, name, actual, want);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopping at the first trace mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        #1 instr = romWords[instrAddr[7:2]];  // Word for the new pc arrives in the same cycle
    end

    initial begin
        #1;
        #((8 + expected.size() + 20) * 10);
        $display("Timeout: the processor did not reach the end of the expected trace");
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset = 1'b1;
        instr = iFormat(6'h2b, 5'd1, 5'd4, 16'h0000);  // Store on the bus until the first fetch

        addInstr(32'h3000, iFormat(6'h0d, 5'd0, 5'd1, 16'h1234));   // ori   $1, $0, 0x1234
        addInstr(32'h3004, iFormat(6'h0f, 5'd0, 5'd2, 16'h8765));   // lui   $2, 0x8765
        addInstr(32'h3008, iFormat(6'h09, 5'd0, 5'd3, 16'hfff8));   // addiu $3, $0, -8
        addInstr(32'h300c, rFormat(5'd1, 5'd2, 5'd4, 5'd0, 6'h21)); // addu  $4, $1, $2
        addInstr(32'h3010, rFormat(5'd1, 5'd3, 5'd5, 5'd0, 6'h23)); // subu  $5, $1, $3
        addInstr(32'h3014, rFormat(5'd4, 5'd1, 5'd6, 5'd0, 6'h24)); // and   $6, $4, $1
        addInstr(32'h3018, rFormat(5'd2, 5'd1, 5'd7, 5'd0, 6'h25)); // or    $7, $2, $1
        addInstr(32'h301c, rFormat(5'd3, 5'd1, 5'd8, 5'd0, 6'h2a)); // slt   $8, $3, $1
        addInstr(32'h3020, rFormat(5'd0, 5'd1, 5'd10, 5'd4, 6'h00)); // sll  $10, $1, 4
        addInstr(32'h3024, iFormat(6'h09, 5'd1, 5'd0, 16'h0005));   // addiu $0, $1, 5
        addInstr(32'h3028, iFormat(6'h2b, 5'd1, 5'd4, 16'h0000));   // sw    $4, 0($1)
        addInstr(32'h302c, iFormat(6'h29, 5'd1, 5'd3, 16'h0006));   // sh    $3, 6($1)
        addInstr(32'h3030, iFormat(6'h28, 5'd1, 5'd3, 16'h0005));   // sb    $3, 5($1)
        addInstr(32'h3034, iFormat(6'h23, 5'd1, 5'd13, 16'h0004));  // lw    $13, 4($1)
        addInstr(32'h3038, iFormat(6'h21, 5'd1, 5'd14, 16'h0006));  // lh    $14, 6($1)
        addInstr(32'h303c, iFormat(6'h20, 5'd1, 5'd15, 16'h0005));  // lb    $15, 5($1)
        addInstr(32'h3040, iFormat(6'h0d, 5'd0, 5'd19, 16'h0002));  // ori   $19, $0, 2
        addInstr(32'h3044, iFormat(6'h09, 5'd19, 5'd19, 16'hffff)); // addiu $19, $19, -1
        addInstr(32'h3048, iFormat(6'h04, 5'd19, 5'd0, 16'h0001));  // beq   $19, $0, +1
        addInstr(32'h304c, iFormat(6'h04, 5'd0, 5'd0, 16'hfffd));   // beq   $0, $0, back to 0x3044
        addInstr(32'h3050, {6'h03, 26'h000_0c16});                  // jal   0x3058
        addInstr(32'h3054, {6'h02, 26'h000_0c17});                  // j     0x305c
        addInstr(32'h3058, rFormat(5'd31, 5'd0, 5'd0, 5'd0, 6'h08)); // jr   $31
        addInstr(32'h305c, iFormat(6'h04, 5'd0, 5'd0, 16'hffff));   // beq   $0, $0, self

        addStep(32'h3000, 1'b1, 5'd1, 32'h0000_1234, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3004, 1'b1, 5'd2, 32'h8765_0000, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3008, 1'b1, 5'd3, 32'hffff_fff8, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h300c, 1'b1, 5'd4, 32'h8765_1234, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3010, 1'b1, 5'd5, 32'h0000_123c, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3014, 1'b1, 5'd6, 32'h0000_1234, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3018, 1'b1, 5'd7, 32'h8765_1234, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h301c, 1'b1, 5'd8, 32'h0000_0001, 1'b0, 32'h0, 4'h0, 32'h0);  // Signed compare
        addStep(32'h3020, 1'b1, 5'd10, 32'h0001_2340, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3024, 1'b1, 5'd0, 32'h0000_1239, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3028, 1'b0, 5'd0, 32'h0, 1'b1, 32'h0000_1234, 4'hf, 32'h8765_1234);
        addStep(32'h302c, 1'b0, 5'd0, 32'h0, 1'b1, 32'h0000_123a, 4'hc, 32'hfff8_0000);
        addStep(32'h3030, 1'b0, 5'd0, 32'h0, 1'b1, 32'h0000_1239, 4'h2, 32'h0000_f800);
        addStep(32'h3034, 1'b1, 5'd13, 32'hfff8_f800, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3038, 1'b1, 5'd14, 32'hffff_fff8, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h303c, 1'b1, 5'd15, 32'hffff_fff8, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3040, 1'b1, 5'd19, 32'h0000_0002, 1'b0, 32'h0, 4'h0, 32'h0);  // $0 still zero
        addStep(32'h3044, 1'b1, 5'd19, 32'h0000_0001, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3048, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h304c, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3044, 1'b1, 5'd19, 32'h0000_0000, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3048, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3050, 1'b1, 5'd31, 32'h0000_3054, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3058, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h3054, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h305c, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 4'h0, 32'h0);
        addStep(32'h305c, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 4'h0, 32'h0);

        #2;  // Trace has settled on the store before the first clock edge
        checkField(0, "memWrite during reset", trace.memWrite, 1'b0);

        for (int cycle = 0; cycle < 8; cycle++) begin
            @(posedge clk);
            #1;
            checkField(cycle, "regWrite during reset", trace.regWrite, 1'b0);
        end
        reset = 1'b0;

        for (int step = 0; step < expected.size(); step++) begin
            @(negedge clk);  // Trace has settled halfway through the cycle
            checkField(step, "pc", trace.pc, expected[step].pc);
            checkField(step, "instrAddr", instrAddr, expected[step].pc);
            checkField(step, "regWrite", trace.regWrite, expected[step].regWrite);
            checkField(step, "memWrite", trace.memWrite, expected[step].memWrite);
            checkField(step, "memByteEnable", trace.memByteEnable, expected[step].memByteEnable);
            if (expected[step].regWrite) begin
                checkField(step, "regAddr", trace.regAddr, expected[step].regAddr);
                checkField(step, "regData", trace.regData, expected[step].regData);
            end
            if (expected[step].memWrite) begin
                checkField(step, "memAddr", trace.memAddr, expected[step].memAddr);
                checkField(step, "memData", trace.memData, expected[step].memData);
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
